// File: compile.f
common/mipsIsaPkg.sv
common/ppuCtrlPkg.sv
rtl/instrClassifier.sv
rtl/ctrlTable.sv
rtl/ppuControlUnit.sv
verif/ppuControlUnitTb.sv

// File: Makefile
TOP = ppuControlUnitTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing -f compile.f --top-module $(TOP) --Mdir obj_dir -o simv
	out="$$(./obj_dir/simv 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

// File: verif/ppuControlUnitTb.sv
`timescale 1ns/1ps

module ppuControlUnitTb
    import mipsIsaPkg::*;
    import ppuCtrlPkg::*;
;

    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 4;
    localparam int CASE_COUNT    = 14; // DEC_NOP up to DEC_SD
    localparam int REG_ROUNDS    = 4;
    localparam int ILLEGAL_KINDS = 5;
    localparam int BURST_LEN     = 12;
    localparam int STROBE_COUNT  = CASE_COUNT * (1 + REG_ROUNDS) + ILLEGAL_KINDS + BURST_LEN;
    // single tests take two cycles each, plus reset and slack
    localparam int LIMIT_CYCLES  = STROBE_COUNT * 2 + RESET_CYCLES + 50;

    logic      clk;
    logic      reset;
    logic      instrValid;
    instr_t    instr;
    logic      ctrlValid;
    ctrlWord_t ctrlWord;
    regAddr_t  writeReg;
    logic      illegalInstr;

    logic [31:0] lcgState = 32'd24470;

    ppuControlUnit dut_i (
        .clk          (clk),
        .reset        (reset),
        .instrValid   (instrValid),
        .instr        (instr),
        .ctrlValid    (ctrlValid),
        .ctrlWord     (ctrlWord),
        .writeReg     (writeReg),
        .illegalInstr (illegalInstr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic regAddr_t randReg();
        logic [31:0] r;
        r = lcgNext();
        return r[27:23]; // upper bits mix better
    endfunction

    function automatic logic [15:0] randImm();
        logic [31:0] r;
        r = lcgNext();
        return r[31:16];
    endfunction

    // expected control word per decoded case
    function automatic ctrlWord_t expectedCtrl(decodeCase_t c);
        ctrlWord_t e;
        e = '0;
        case (c)
            DEC_ADDIU: begin
                e.srcOperand = SRC_IMM;
                e.aluOp = ALU_ADD;
                e.rfEnable = 1'b1;
                e.destSel = DEST_RT;
            end
            DEC_ADDU, DEC_SUBU: begin
                e.aluOp = (c == DEC_SUBU) ? ALU_SUB : ALU_ADD;
                e.rfEnable = 1'b1;
                e.destSel = DEST_RD;
            end
            DEC_LBU: begin
                e.srcOperand = SRC_IMM;
                e.aluOp = ALU_ADD;
                e.loadInstr = 1'b1;
                e.rfEnable = 1'b1;
                e.memEnable = 1'b1;
                e.destSel = DEST_RT;
            end
            DEC_LB: begin
                e.srcOperand = SRC_IMM;
                e.aluOp = ALU_ADD;
                e.loadInstr = 1'b1;
                e.rfEnable = 1'b1;
                e.memEnable = 1'b1;
                e.memSignExt = 1'b1; // only the signed load
                e.destSel = DEST_RT;
            end
            DEC_LUI: begin
                e.srcOperand = SRC_UPPER;
                e.aluOp = ALU_LUI;
                e.rfEnable = 1'b1;
                e.destSel = DEST_RT;
            end
            DEC_BGTZ: begin
                e.aluOp = ALU_CMP;
                e.branchInstr = 1'b1;
                e.targetAddrInstr = 1'b1;
                e.rsAddrMux = 1'b1;
            end
            DEC_BGEZ: begin
                e.aluOp = ALU_CMP;
                e.branchInstr = 1'b1;
                e.targetAddrInstr = 1'b1;
                e.condJump = 1'b1;
                e.uncondJump = 1'b1;
            end
            DEC_BEQ: begin
                e.branchInstr = 1'b1;
                e.targetAddrInstr = 1'b1;
                e.condJump = 1'b1;
            end
            DEC_JAL: begin
                e.srcOperand = SRC_LINK;
                e.aluOp = ALU_LINK;
                e.rfEnable = 1'b1;
                e.targetAddrInstr = 1'b1;
                e.condJump = 1'b1;
                e.uncondJump = 1'b1;
                e.destSel = DEST_R31;
            end
            DEC_JR: begin
                e.condJump = 1'b1;
                e.uncondJump = 1'b1;
                e.rsAddrMux = 1'b1;
            end
            DEC_SB, DEC_SD: begin
                e.memWrite = 1'b1;
                e.memEnable = 1'b1;
            end
            default: e = '0;
        endcase
        return e;
    endfunction

    function automatic regAddr_t expectedWriteReg(decodeCase_t c, instr_t w);
        case (c)
            DEC_ADDU, DEC_SUBU: return w[15:11];
            DEC_ADDIU, DEC_LB, DEC_LBU, DEC_LUI: return w[20:16];
            DEC_JAL: return 5'd31;
            default: return 5'd0;
        endcase
    endfunction

    function automatic instr_t illegalWord(int kind);
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t rd;
        logic [15:0] imm;
        rs = randReg();
        rt = randReg();
        rd = randReg();
        imm = randImm();
        case (kind)
            0: return {6'b000000, 5'd0, rt, rd, 5'd3, 6'b000000}; // SLL, shamt keeps it nonzero
            1: return {6'b000000, rs, rt, rd, 5'd0, 6'b101010};   // SLT
            2: return {6'b000001, rs, 5'b00000, imm};             // BLTZ
            3: return {6'b100011, rs, rt, imm};                   // LW
            default: return {6'b001101, rs, rt, imm};             // ORI
        endcase
    endfunction

    function automatic instr_t buildInstr(decodeCase_t c);
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t rd;
        logic [15:0] imm;
        logic [31:0] r;
        rs = randReg();
        rt = randReg();
        rd = randReg();
        imm = randImm();
        case (c)
            DEC_NOP:   return '0;
            DEC_ADDU:  return {6'b000000, rs, rt, rd, 5'd0, 6'b100001};
            DEC_SUBU:  return {6'b000000, rs, rt, rd, 5'd0, 6'b100011};
            DEC_JR:    return {6'b000000, rs, 15'd0, 6'b001000};
            DEC_ADDIU: return {6'b001001, rs, rt, imm};
            DEC_LB:    return {6'b100000, rs, rt, imm};
            DEC_LBU:   return {6'b100100, rs, rt, imm};
            DEC_LUI:   return {6'b001111, 5'd0, rt, imm};
            DEC_BGTZ:  return {6'b000111, rs, 5'd0, imm};
            DEC_BGEZ:  return {6'b000001, rs, 5'b00001, imm};
            DEC_BEQ:   return {6'b000100, rs, rt, imm};
            DEC_JAL:   return {6'b000011, rs, rt, imm}; // 26-bit target
            DEC_SB:    return {6'b101000, rs, rt, imm};
            DEC_SD:    return {6'b111111, rs, rt, imm};
            default: begin
                r = lcgNext();
                return illegalWord(int'(r[31:24]) % ILLEGAL_KINDS);
            end
        endcase
    endfunction

    task automatic abortRun(string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic compareCtrl(string testName, ctrlWord_t expected, ctrlWord_t actual);
        if (actual !== expected) begin
            abortRun($sformatf("mismatch %s ctrlWord expected %h actual %h",
                testName, expected, actual));
        end
    endtask

    task automatic compareReg(string testName, regAddr_t expected, regAddr_t actual);
        if (actual !== expected) begin
            abortRun($sformatf("mismatch %s writeReg expected %0d actual %0d",
                testName, expected, actual));
        end
    endtask

    task automatic compareBit(string testName, logic expected, logic actual);
        if (actual !== expected) begin
            abortRun($sformatf("mismatch %s expected %b actual %b", testName, expected, actual));
        end
    endtask

    task automatic checkResult(string testName, decodeCase_t c, instr_t w);
        compareBit({testName, " ctrlValid"}, 1'b1, ctrlValid);
        compareCtrl(testName, expectedCtrl(c), ctrlWord);
        compareReg(testName, expectedWriteReg(c, w), writeReg);
        compareBit({testName, " illegalInstr"}, c == DEC_ILLEGAL, illegalInstr);
    endtask

    // one strobe, result checked mid-cycle one clock later
    task automatic runSingle(string testName, decodeCase_t c, instr_t w);
        @(posedge clk);
        instrValid <= 1'b1;
        instr      <= w;
        @(posedge clk);
        instrValid <= 1'b0;
        @(negedge clk);
        checkResult(testName, c, w);
    endtask

    task automatic testResetValues();
        @(posedge clk);
        @(negedge clk);
        compareBit("reset ctrlValid", 1'b0, ctrlValid);
        compareCtrl("reset", '0, ctrlWord);
        compareReg("reset", '0, writeReg);
        compareBit("reset illegalInstr", 1'b0, illegalInstr);
    endtask

    task automatic testCaseTable();
        decodeCase_t c;
        for (int k = 0; k < CASE_COUNT; k++) begin
            c = decodeCase_t'(4'(k));
            runSingle($sformatf("caseTable %s", c.name()), c, buildInstr(c));
        end
    endtask

    task automatic testWriteReg();
        decodeCase_t c;
        for (int r = 0; r < REG_ROUNDS; r++) begin
            for (int k = 0; k < CASE_COUNT; k++) begin
                c = decodeCase_t'(4'(k));
                runSingle($sformatf("writeReg %s round %0d", c.name(), r), c, buildInstr(c));
            end
        end
    endtask

    task automatic testIllegal();
        for (int k = 0; k < ILLEGAL_KINDS; k++) begin
            runSingle($sformatf("illegal kind %0d", k), DEC_ILLEGAL, illegalWord(k));
        end
    endtask

    task automatic testBurst();
        decodeCase_t burstCase [BURST_LEN];
        instr_t      burstWord [BURST_LEN];
        logic [31:0] r;
        for (int i = 0; i < BURST_LEN; i++) begin
            r = lcgNext();
            burstCase[i] = decodeCase_t'(4'(r[31:16] % 15)); // DEC_ILLEGAL included
            burstWord[i] = buildInstr(burstCase[i]);
        end
        @(posedge clk);
        instrValid <= 1'b1;
        instr      <= burstWord[0];
        for (int i = 0; i < BURST_LEN; i++) begin
            @(posedge clk);
            if (i + 1 < BURST_LEN) begin
                instr <= burstWord[i + 1];
            end else begin
                instrValid <= 1'b0;
            end
            @(negedge clk);
            checkResult($sformatf("burst %0d %s", i, burstCase[i].name()),
                burstCase[i], burstWord[i]);
        end
        @(posedge clk);
        @(negedge clk);
        compareBit("burst gap ctrlValid", 1'b0, ctrlValid);
    endtask

    initial begin
        reset      = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        testResetValues();
        testCaseTable();
        testWriteReg();
        testIllegal();
        testBurst();
        $display("TEST PASSED");
        $finish;
    end

    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        abortRun($sformatf("timeout after %0d cycles, the tests did not finish", LIMIT_CYCLES));
    end

endmodule

// File: rtl/ppuControlUnit.sv
`timescale 1ns/1ps

module ppuControlUnit
    import mipsIsaPkg::*;
    import ppuCtrlPkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      instrValid,
    input  instr_t    instr,
    output logic      ctrlValid,
    output ctrlWord_t ctrlWord,
    output regAddr_t  writeReg,
    output logic      illegalInstr
);

    decodeCase_t decodeCase;
    ctrlWord_t   nextCtrlWord;
    regAddr_t    nextWriteReg;
    logic        nextIllegal;

    instrClassifier classifier_i (
        .instr      (instr),
        .decodeCase (decodeCase)
    );

    ctrlTable table_i (
        .clk        (clk),
        .reset      (reset),
        .decodeCase (decodeCase),
        .instr      (instr),
        .ctrlWord   (nextCtrlWord),
        .writeReg   (nextWriteReg),
        .illegal    (nextIllegal)
    );

    // single output stage, one decode per cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrlValid    <= 1'b0;
            ctrlWord     <= CTRL_ZERO;
            writeReg     <= '0;
            illegalInstr <= 1'b0;
        end else begin
            ctrlValid <= instrValid;
            if (instrValid) begin
                ctrlWord     <= nextCtrlWord;
                writeReg     <= nextWriteReg;
                illegalInstr <= nextIllegal;
            end
        end
    end

    aValidKnown: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(ctrlValid))
        else $error("ctrlValid unknown after reset");

endmodule

// File: rtl/ctrlTable.sv
`timescale 1ns/1ps

module ctrlTable
    import mipsIsaPkg::*;
    import ppuCtrlPkg::*;
(
    input  logic        clk,   // samples the checks below
    input  logic        reset,
    input  decodeCase_t decodeCase,
    input  instr_t      instr,
    output ctrlWord_t   ctrlWord,
    output regAddr_t    writeReg,
    output logic        illegal
);

    always_comb begin
        ctrlWord = CTRL_ZERO;
        case (decodeCase)
            DEC_ADDIU: begin
                ctrlWord.srcOperand = SRC_IMM;
                ctrlWord.aluOp      = ALU_ADD;
                ctrlWord.rfEnable   = 1'b1;
                ctrlWord.destSel    = DEST_RT;
            end
            DEC_ADDU: begin
                ctrlWord.srcOperand = SRC_REG;
                ctrlWord.aluOp      = ALU_ADD;
                ctrlWord.rfEnable   = 1'b1;
                ctrlWord.destSel    = DEST_RD;
            end
            DEC_SUBU: begin
                ctrlWord.srcOperand = SRC_REG;
                ctrlWord.aluOp      = ALU_SUB;
                ctrlWord.rfEnable   = 1'b1;
                ctrlWord.destSel    = DEST_RD;
            end
            DEC_LB, DEC_LBU: begin
                ctrlWord.srcOperand = SRC_IMM; // base + offset
                ctrlWord.aluOp      = ALU_ADD;
                ctrlWord.loadInstr  = 1'b1;
                ctrlWord.rfEnable   = 1'b1;
                ctrlWord.memEnable  = 1'b1;
                ctrlWord.memSignExt = (decodeCase == DEC_LB);
                ctrlWord.destSel    = DEST_RT;
            end
            DEC_LUI: begin
                ctrlWord.srcOperand = SRC_UPPER;
                ctrlWord.aluOp      = ALU_LUI;
                ctrlWord.rfEnable   = 1'b1;
                ctrlWord.destSel    = DEST_RT;
            end
            DEC_BGTZ: begin
                ctrlWord.aluOp           = ALU_CMP;
                ctrlWord.branchInstr     = 1'b1;
                ctrlWord.targetAddrInstr = 1'b1;
                ctrlWord.rsAddrMux       = 1'b1;
            end
            DEC_BGEZ: begin
                // same jump bits as a JAL, compared in the ALU
                ctrlWord.aluOp           = ALU_CMP;
                ctrlWord.branchInstr     = 1'b1;
                ctrlWord.targetAddrInstr = 1'b1;
                ctrlWord.condJump        = 1'b1;
                ctrlWord.uncondJump      = 1'b1;
            end
            DEC_BEQ: begin
                ctrlWord.branchInstr     = 1'b1;
                ctrlWord.targetAddrInstr = 1'b1;
                ctrlWord.condJump        = 1'b1;
            end
            DEC_JAL: begin
                ctrlWord.srcOperand      = SRC_LINK;
                ctrlWord.aluOp           = ALU_LINK;
                ctrlWord.rfEnable        = 1'b1;
                ctrlWord.targetAddrInstr = 1'b1;
                ctrlWord.condJump        = 1'b1;
                ctrlWord.uncondJump      = 1'b1;
                ctrlWord.destSel         = DEST_R31;
            end
            DEC_JR: begin
                ctrlWord.condJump   = 1'b1;
                ctrlWord.uncondJump = 1'b1;
                ctrlWord.rsAddrMux  = 1'b1; // target comes from rs
            end
            DEC_SB, DEC_SD: begin
                ctrlWord.memWrite  = 1'b1;
                ctrlWord.memEnable = 1'b1;
            end
            default: ctrlWord = CTRL_ZERO; // NOP and illegal words
        endcase
    end

    // destination register number from the selected field
    always_comb begin
        case (ctrlWord.destSel)
            DEST_RD:   writeReg = getRd(instr);
            DEST_RT:   writeReg = getRt(instr);
            DEST_R31:  writeReg = LINK_REG;
            DEST_NONE: writeReg = '0;
        endcase
    end

    assign illegal = (decodeCase == DEC_ILLEGAL);

    aStoreEnablesMem: assert property (@(posedge clk) disable iff (reset)
        ctrlWord.memWrite |-> ctrlWord.memEnable)
        else $error("store without memory enable");

    aLoadWritesBack: assert property (@(posedge clk) disable iff (reset)
        ctrlWord.loadInstr |-> ctrlWord.rfEnable)
        else $error("load without register write");

    aIllegalIsQuiet: assert property (@(posedge clk) disable iff (reset)
        illegal |-> (ctrlWord == CTRL_ZERO))
        else $error("illegal word with nonzero control");

endmodule

// File: rtl/instrClassifier.sv
`timescale 1ns/1ps

module instrClassifier
    import mipsIsaPkg::*;
    import ppuCtrlPkg::*;
(
    input  instr_t      instr,
    output decodeCase_t decodeCase
);

    opcode_t   opcode;
    funct_t    funct;
    regimmRt_t regimmRt;

    assign opcode   = getOpcode(instr);
    assign funct    = getFunct(instr);
    assign regimmRt = getRegimmRt(instr);

    always_comb begin
        decodeCase = DEC_ILLEGAL;
        if (instr == '0) begin
            // all-zero word wins over the SLL encoding
            decodeCase = DEC_NOP;
        end else begin
            case (opcode)
                OP_RTYPE: begin
                    case (funct)
                        FN_ADDU: decodeCase = DEC_ADDU;
                        FN_SUBU: decodeCase = DEC_SUBU;
                        FN_JR:   decodeCase = DEC_JR;
                        default: decodeCase = DEC_ILLEGAL; // other R-type functions
                    endcase
                end
                OP_REGIMM: begin
                    if (regimmRt == RT_BGEZ) begin
                        decodeCase = DEC_BGEZ;
                    end else begin
                        decodeCase = DEC_ILLEGAL;
                    end
                end
                OP_ADDIU: decodeCase = DEC_ADDIU;
                OP_LB:    decodeCase = DEC_LB;
                OP_LBU:   decodeCase = DEC_LBU;
                OP_LUI:   decodeCase = DEC_LUI;
                OP_BGTZ:  decodeCase = DEC_BGTZ;
                OP_BEQ:   decodeCase = DEC_BEQ;   // includes the plain B form
                OP_JAL:   decodeCase = DEC_JAL;
                OP_SB:    decodeCase = DEC_SB;
                OP_SD:    decodeCase = DEC_SD;
                default:  decodeCase = DEC_ILLEGAL;
            endcase
        end
    end

endmodule

// File: common/ppuCtrlPkg.sv
package ppuCtrlPkg;

    // ALU operation codes as seen by the execute stage
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b0001,
        ALU_CMP  = 4'b1010,
        ALU_LUI  = 4'b1011,
        ALU_LINK = 4'b1100
    } aluOp_t;

    // second ALU operand source
    typedef enum logic [2:0] {
        SRC_REG   = 3'b000,
        SRC_LINK  = 3'b011, // pc + 8 for the link value
        SRC_IMM   = 3'b100,
        SRC_UPPER = 3'b101
    } srcOperand_t;

    typedef enum logic [1:0] {
        DEST_NONE = 2'b00,
        DEST_RD   = 2'b01,
        DEST_RT   = 2'b10,
        DEST_R31  = 2'b11
    } destSel_t;

    // one value per supported instruction
    typedef enum logic [3:0] {
        DEC_NOP,
        DEC_ADDIU,
        DEC_ADDU,
        DEC_SUBU,
        DEC_LB,
        DEC_LBU,
        DEC_LUI,
        DEC_BGTZ,
        DEC_BGEZ,
        DEC_BEQ,
        DEC_JAL,
        DEC_JR,
        DEC_SB,
        DEC_SD,
        DEC_ILLEGAL
    } decodeCase_t;

    // 24-bit control word, bit 23 first
    typedef struct packed {
        logic        addrMux;
        logic        rsAddrMux;
        logic        condJump;     // any jump or taken-branch path
        logic        uncondJump;
        destSel_t    destSel;
        srcOperand_t srcOperand;
        aluOp_t      aluOp;
        logic        branchInstr;
        logic        loadInstr;
        logic        rfEnable;
        logic        targetAddrInstr;
        logic [1:0]  memSize;      // 00 byte
        logic        memWrite;
        logic        memSignExt;
        logic        memEnable;
        logic        hiEnable;
        logic        loEnable;
    } ctrlWord_t;

    localparam ctrlWord_t CTRL_ZERO = '0;

endpackage

// File: common/mipsIsaPkg.sv
package mipsIsaPkg;

    localparam int INSTR_W  = 32;
    localparam int OPCODE_W = 6;
    localparam int FUNCT_W  = 6;
    localparam int REG_W    = 5;

    // bit positions of the instruction fields
    localparam int OPCODE_LSB = 26;
    localparam int RT_LSB     = 16;
    localparam int RD_LSB     = 11;
    localparam int FUNCT_LSB  = 0;

    typedef logic [INSTR_W-1:0] instr_t;
    typedef logic [REG_W-1:0]   regAddr_t;

    // major opcodes, bits 31:26
    typedef enum logic [OPCODE_W-1:0] {
        OP_RTYPE  = 6'b000000,
        OP_REGIMM = 6'b000001,
        OP_JAL    = 6'b000011,
        OP_BEQ    = 6'b000100,
        OP_BGTZ   = 6'b000111,
        OP_ADDIU  = 6'b001001,
        OP_LUI    = 6'b001111,
        OP_LB     = 6'b100000,
        OP_LBU    = 6'b100100,
        OP_SB     = 6'b101000,
        OP_SD     = 6'b111111
    } opcode_t;

    // function field of R-type words
    typedef enum logic [FUNCT_W-1:0] {
        FN_JR   = 6'b001000,
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011
    } funct_t;

    // rt field of REGIMM words selects the branch flavour
    typedef enum logic [REG_W-1:0] {
        RT_BGEZ = 5'b00001
    } regimmRt_t;

    localparam regAddr_t LINK_REG = 5'd31; // return address register for JAL

    function automatic opcode_t getOpcode(instr_t word);
        return opcode_t'(word[OPCODE_LSB +: OPCODE_W]);
    endfunction

    function automatic funct_t getFunct(instr_t word);
        return funct_t'(word[FUNCT_LSB +: FUNCT_W]);
    endfunction

    function automatic regAddr_t getRt(instr_t word);
        return word[RT_LSB +: REG_W];
    endfunction

    function automatic regAddr_t getRd(instr_t word);
        return word[RD_LSB +: REG_W];
    endfunction

    // same bits as rt, read as a REGIMM selector
    function automatic regimmRt_t getRegimmRt(instr_t word);
        return regimmRt_t'(word[RT_LSB +: REG_W]);
    endfunction

endpackage
